/* stb_config.svh */
// Build-time constants for the strobe generator, included by the package and the RTL.
`ifndef STB_CONFIG_SVH
`define STB_CONFIG_SVH

// width of the period counter.
// 12 bits keeps an overflow reachable in simulation.
`define STB_CNT_WIDTH 12

// cycles the strobe stays low at the end of each period.
`define STB_ZERO_HOLD 5

// flops in the sig_i synchronizer, at least 2.
`define STB_SYNC_STAGES 2

`endif

/* stb_pkg.sv */
// Shared types of the strobe generator, imported by the control and datapath modules.
`include "stb_config.svh"

package stb_pkg;

   // cycle count, also used for the measured period.
   typedef logic [`STB_CNT_WIDTH-1:0] cnt_t;

   // measurement sequence of the control FSM.
   typedef enum logic [1:0] {
      GEN,               // strobe generation, ready.
      FIND_FIRST_EDGE,   // waiting for the first rise.
      FIND_SECOND_EDGE   // counting until the second rise.
   } ctrl_state_e;

   // control to strobe timer.
   typedef struct packed {
      logic gen_en;  // strobe allowed.
      logic load;    // one-cycle, period is valid.
      cnt_t period;  // measured period in cycles.
   } meas_t;

endpackage

/* stb_edge_detect.sv */
// Synchronizes the slow input sig_i and pulses rise_o once per rising edge.
`timescale 1ns/1ps
`include "stb_config.svh"

module stb_edge_detect (
   input  logic clk_i,
   input  logic arst_i,
   input  logic sig_i,
   output logic rise_o
);

   localparam int STAGES = `STB_SYNC_STAGES;

   logic [STAGES-1:0] sync_q;   // bit 0 is the first flop.
   logic              prev_q;   // synchronized level, one cycle old.
   logic              rise_q;

   always_ff @(posedge clk_i, posedge arst_i) begin
      if (arst_i) begin
         sync_q <= '0;
         prev_q <= 1'b0;
         rise_q <= 1'b0;
      end else begin
         sync_q <= {sync_q[STAGES-2:0], sig_i};
         prev_q <= sync_q[STAGES-1];
         rise_q <= sync_q[STAGES-1] & ~prev_q;   // registered edge.
      end
   end

   // total latency is STAGES plus one cycle; it is the same on
   // every edge, so it drops out of the measured period.
   assign rise_o = rise_q;

endmodule

/* stb_period_counter.sv */
// Saturating cycle counter used by the control FSM to time the input period.
`timescale 1ns/1ps

module stb_period_counter (
   input  logic          clk_i,
   input  logic          arst_i,
   input  logic          clear_i,
   output stb_pkg::cnt_t count_o,
   output logic          ovf_o
);

   import stb_pkg::*;

   localparam cnt_t CNT_MAX = '1;

   cnt_t cnt_q;
   logic sat;

   assign sat = (cnt_q == CNT_MAX);   // held at the top.

   always_ff @(posedge clk_i, posedge arst_i) begin
      if (arst_i) begin
         cnt_q <= '0;
      end else if (clear_i) begin
         cnt_q <= '0;                  // restart on next edge.
      end else if (!sat) begin
         cnt_q <= cnt_q + cnt_t'(1);
      end
   end

   // ovf stays high until the next clear.
   assign ovf_o   = sat;
   assign count_o = cnt_q;

endmodule

/* stb_ctrl.sv */
// Control FSM that runs a period measurement on request and hands the result to the timer.
`timescale 1ns/1ps

module stb_ctrl (
   input  logic           clk_i,
   input  logic           arst_i,
   input  logic           run_det_i,
   input  logic           rise_i,
   input  stb_pkg::cnt_t  count_i,
   input  logic           ovf_i,
   output logic           clear_o,
   output stb_pkg::meas_t meas_o,
   output logic           rdy_o,
   output logic           err_o
);

   import stb_pkg::*;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        loaded_q;   // a valid period has been loaded.
   logic        err_q;
   logic        good_meas;

   // second edge with the counter still in range.
   assign good_meas = (state_q == FIND_SECOND_EDGE) & rise_i & ~ovf_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         GEN: begin
            if (run_det_i) begin
               state_d = FIND_FIRST_EDGE;
            end
         end
         FIND_FIRST_EDGE: begin
            if (rise_i) begin
               state_d = FIND_SECOND_EDGE;
            end
         end
         FIND_SECOND_EDGE: begin
            if (rise_i) begin
               state_d = GEN;   // valid or not, back to generation.
            end
         end
         default: begin
            state_d = GEN;
         end
      endcase
   end

   always_ff @(posedge clk_i, posedge arst_i) begin
      if (arst_i) begin
         state_q  <= GEN;
         loaded_q <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         if (good_meas) begin
            loaded_q <= 1'b1;
         end
         if (state_q == GEN && run_det_i) begin
            err_q <= 1'b0;          // new run drops the old error.
         end else if (state_q == FIND_SECOND_EDGE && ovf_i) begin
            err_q <= 1'b1;          // sticky until next run.
         end
      end
   end

   // counter starts at zero in the cycle after the first rise, so the
   // value seen on the second rise is one short of the period.
   assign clear_o = (state_q == FIND_FIRST_EDGE) & rise_i;

   assign meas_o.gen_en = loaded_q & (state_q == GEN);
   assign meas_o.load   = good_meas;
   assign meas_o.period = count_i + cnt_t'(1);

   assign rdy_o = (state_q == GEN);
   assign err_o = err_q;

endmodule

/* stb_strobe_timer.sv */
// Periodic strobe generator that replays the measured period with a low hold window at its end.
`timescale 1ns/1ps
`include "stb_config.svh"

module stb_strobe_timer (
   input  logic           clk_i,
   input  logic           arst_i,
   input  stb_pkg::meas_t meas_i,
   input  logic           oe_i,
   output logic           stb_o
);

   import stb_pkg::*;

   localparam cnt_t HOLD = cnt_t'(`STB_ZERO_HOLD);

   cnt_t period_q;
   cnt_t phase_q;
   logic stb_q;

   cnt_t period_d;
   cnt_t phase_d;
   logic window_d;
   logic strobe;

   always_comb begin
      period_d = meas_i.load ? meas_i.period : period_q;
      if (meas_i.load) begin
         phase_d = '0;                       // restart on a new period.
      end else if (phase_q == period_q - cnt_t'(1)) begin
         phase_d = '0;
      end else begin
         phase_d = phase_q + cnt_t'(1);
      end
      // high up to the start of the hold window; a period no longer
      // than the hold leaves no high phase at all.
      window_d = (period_d > HOLD) && (phase_d < period_d - HOLD);
   end

   always_ff @(posedge clk_i, posedge arst_i) begin
      if (arst_i) begin
         period_q <= '0;
         phase_q  <= '0;
         stb_q    <= 1'b0;
      end else begin
         period_q <= period_d;
         phase_q  <= phase_d;
         stb_q    <= window_d;   // lines up with phase_q.
      end
   end

   assign strobe = stb_q & meas_i.gen_en;   // low while measuring.
   assign stb_o  = strobe & oe_i;           // oe acts in the same cycle.

endmodule

/* stb_gen_top.sv */
// Top level of the period-measuring strobe generator; instantiate this as the DUT.
`timescale 1ns/1ps

module stb_gen_top (
   input  logic clk_i,
   input  logic arst_i,
   input  logic sig_i,
   input  logic run_det_i,
   input  logic oe_i,
   output logic err_o,
   output logic rdy_o,
   output logic stb_o
);

   import stb_pkg::*;

   logic  rise;
   logic  clear;
   cnt_t  count;
   logic  ovf;
   meas_t meas;

   stb_edge_detect u_edge (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .sig_i  (sig_i),
      .rise_o (rise)
   );

   stb_period_counter u_cnt (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .clear_i (clear),
      .count_o (count),
      .ovf_o   (ovf)
   );

   stb_ctrl u_ctrl (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .run_det_i (run_det_i),
      .rise_i    (rise),
      .count_i   (count),
      .ovf_i     (ovf),
      .clear_o   (clear),
      .meas_o    (meas),
      .rdy_o     (rdy_o),
      .err_o     (err_o)
   );

   stb_strobe_timer u_timer (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .meas_i (meas),
      .oe_i   (oe_i),
      .stb_o  (stb_o)
   );

endmodule

/* tb_clkgen.sv */
// Testbench clock and reset source; a 10 ns clock with reset held for the first 4 cycles.
`timescale 1ns/1ps

module tb_clkgen (
   output logic clk_o,
   output logic arst_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;   // 10 ns period.
   end

   initial begin
      arst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      #1 arst_o = 1'b0;            // released just after the 4th edge.
   end

endmodule

/* stb_gen_props.sv */
// Port-level assertions for the strobe generator, bound to the top level by the testbench.
`timescale 1ns/1ps
`include "stb_config.svh"

module stb_gen_props (
   input logic clk_i,
   input logic arst_i,
   input logic sig_i,
   input logic run_det_i,
   input logic oe_i,
   input logic err_o,
   input logic rdy_o,
   input logic stb_o
);

   localparam int HOLD    = `STB_ZERO_HOLD;
   localparam int CNT_MAX = (1 << `STB_CNT_WIDTH) - 1;

   int fail_count = 0;

   logic sig_q, stb_q, rdy_q, ok_q;
   logic started, track;
   int   sig_cnt, sig_gap, rises, exp_per, stb_gap, hi_cnt;
   logic sig_rise, stb_rise, stb_fall, rdy_rise, ok, new_run;

   assign sig_rise = sig_i & ~sig_q;
   assign stb_rise = stb_o & ~stb_q;
   assign stb_fall = ~stb_o & stb_q;
   assign rdy_rise = rdy_o & ~rdy_q;
   assign ok       = rdy_o & oe_i;        // strobe visible.
   assign new_run  = run_det_i & rdy_o;

   always_ff @(posedge clk_i, posedge arst_i) begin
      if (arst_i) begin
         sig_q    <= 1'b0;
         stb_q    <= 1'b0;
         rdy_q    <= 1'b1;
         ok_q     <= 1'b0;
         started  <= 1'b0;
         track    <= 1'b0;
         sig_cnt  <= 0;
         sig_gap  <= 0;
         rises    <= 0;
         exp_per  <= 0;
         stb_gap  <= 0;
         hi_cnt   <= 0;
      end else begin
         sig_q <= sig_i;
         stb_q <= stb_o;
         rdy_q <= rdy_o;
         ok_q  <= ok;
         if (new_run) begin
            started <= 1'b1;
         end
         if (sig_rise) begin
            sig_gap <= sig_cnt;           // input period seen at the ports.
            sig_cnt <= 1;
         end else if (sig_cnt < (1 << 20)) begin
            sig_cnt <= sig_cnt + 1;
         end
         if (new_run) begin
            rises <= 0;
         end else if (sig_rise && rises < 3) begin
            rises <= rises + 1;
         end
         if (rdy_rise && sig_gap <= CNT_MAX) begin
            exp_per <= sig_gap;           // overflow keeps the old period.
         end
         if (!ok) begin
            track   <= 1'b0;
            stb_gap <= 0;
         end else if (stb_rise && ok_q) begin
            track   <= 1'b1;              // real period start.
            stb_gap <= 1;
            hi_cnt  <= 1;
         end else begin
            stb_gap <= stb_gap + 1;
            if (stb_o) begin
               hi_cnt <= hi_cnt + 1;
            end
         end
      end
   end

   task automatic flag_failure(input string msg);
      fail_count++;
      $error("%s", msg);
   endtask

   a_idle: assert property (@(posedge clk_i) !started |-> rdy_o && !err_o && !stb_o)
      else flag_failure("outputs not idle before the first run");

   a_meas_low: assert property (@(posedge clk_i) disable iff (arst_i) !rdy_o |-> !stb_o)
      else flag_failure("strobe high while measuring");

   a_run: assert property (@(posedge clk_i) disable iff (arst_i) new_run |=> !rdy_o && !err_o)
      else flag_failure("run_det_i did not start a measurement");

   a_two_edges: assert property (@(posedge clk_i) disable iff (arst_i) rdy_rise |-> rises >= 2)
      else flag_failure("rdy_o returned before two input edges");

   a_period: assert property (@(posedge clk_i) disable iff (arst_i)
      ok && ok_q && stb_rise && track |-> stb_gap == exp_per)
      else flag_failure("strobe period differs from input period");

   a_width: assert property (@(posedge clk_i) disable iff (arst_i)
      ok && ok_q && stb_fall && track |-> hi_cnt == exp_per - HOLD)
      else flag_failure("strobe high time wrong");

   // a known period must keep the strobe running.
   a_live: assert property (@(posedge clk_i) disable iff (arst_i)
      ok && exp_per != 0 |-> stb_gap <= exp_per)
      else flag_failure("strobe stopped during generation");

   a_oe: assert property (@(posedge clk_i) disable iff (arst_i) !oe_i |-> !stb_o)
      else flag_failure("strobe high with oe_i low");

   a_err: assert property (@(posedge clk_i) disable iff (arst_i)
      rdy_rise |-> err_o == (sig_gap > CNT_MAX))
      else flag_failure("err_o does not match the measured input gap");

endmodule

bind stb_gen_top stb_gen_props u_props (.*);

/* tb_stb_gen.sv */
// Testbench top for the strobe generator; drives the measurement phases, checking is in the props.
`timescale 1ns/1ps

module tb_stb_gen;

   localparam int MAX_CYCLES = 20000;   // all phases plus margin.
   localparam int LONG_LOW   = 5000;    // longer than the 4096 counter range.

   logic clk;
   logic arst;
   logic sig_i;
   logic run_det_i;
   logic oe_i;
   logic err_o;
   logic rdy_o;
   logic stb_o;

   int seed = 32'h6628fadf;
   int cycles = 0;
   int p1;
   int p2;
   int p3;

   tb_clkgen u_clk (
      .clk_o  (clk),
      .arst_o (arst)
   );

   stb_gen_top DUT (
      .clk_i     (clk),
      .arst_i    (arst),
      .sig_i     (sig_i),
      .run_det_i (run_det_i),
      .oe_i      (oe_i),
      .err_o     (err_o),
      .rdy_o     (rdy_o),
      .stb_o     (stb_o)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("FAIL at %0t ns: %s is %b, expected %b", $time, name, got, exp));
      end
   endtask

   function automatic int pick_period(input int avoid);
      int p;
      p = avoid;
      while (p == avoid) begin
         p = 20 + int'($unsigned($random(seed)) % 41);   // 20 to 60.
      end
      return p;
   endfunction

   // one full period of sig_i, rise at its first cycle.
   task automatic drive_period(input int p, input bit pulse_run, input bit blink_oe);
      int i;
      for (i = 0; i < p; i++) begin
         @(posedge clk);
         #1;
         if (i == 0) begin
            sig_i = 1'b1;
         end
         if (i == p / 2) begin
            sig_i = 1'b0;
         end
         run_det_i = pulse_run && (i == 4);   // clear of the edge pipeline.
         if (blink_oe) begin
            oe_i = !(i >= p / 3 && i < p / 3 + 4);
         end
      end
   endtask

   task automatic hold_low(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(posedge clk);
         #1;
         sig_i = 1'b0;
      end
   endtask

   task automatic wait_ready(input int p);
      int n;
      n = 0;
      while (!rdy_o) begin
         if (n == 8) begin
            abort_run("rdy_o did not return after a measurement");
         end
         drive_period(p, 1'b0, 1'b0);
         n++;
      end
   endtask

   // n periods of generation, oe_i blinks in the second one.
   task automatic settle(input int p, input int n);
      int k;
      for (k = 0; k < n; k++) begin
         drive_period(p, 1'b0, k == 1);
      end
   endtask

   task automatic measure(input int p);
      drive_period(p, 1'b1, 1'b0);
      wait_ready(p);
   endtask

   // cycle budget for the whole run.
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         abort_run("test timed out before all phases finished");
      end
   end

   // property checker failures end the run here as well.
   always @(negedge clk) begin
      if (DUT.u_props.fail_count != 0) begin
         abort_run("a property check on the DUT ports failed");
      end
   end

   initial begin
      sig_i     = 1'b0;
      run_det_i = 1'b0;
      oe_i      = 1'b1;
      @(negedge arst);

      // idle, no period known yet.
      drive_period(30, 1'b0, 1'b0);
      drive_period(30, 1'b0, 1'b1);

      // two measurements at different periods.
      p1 = pick_period(0);
      p2 = pick_period(p1);
      measure(p1);
      settle(p1, 5);
      measure(p2);
      settle(p2, 5);

      // overflow, old period must stay.
      drive_period(p2, 1'b1, 1'b0);
      drive_period(p2, 1'b0, 1'b0);   // first edge.
      hold_low(LONG_LOW);
      wait_ready(p2);                 // second edge far too late.
      check_bit("err_o after overflow", err_o, 1'b1);
      settle(p2, 5);

      // new run clears the error.
      p3 = pick_period(p2);
      measure(p3);
      check_bit("err_o after valid run", err_o, 1'b0);
      settle(p3, 5);

      if (DUT.u_props.fail_count == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         abort_run("property checker reported errors");
      end
   end

endmodule

/* flist.f */
+incdir+.
stb_pkg.sv
stb_edge_detect.sv
stb_period_counter.sv
stb_ctrl.sv
stb_strobe_timer.sv
stb_gen_top.sv
tb_clkgen.sv
stb_gen_props.sv
tb_stb_gen.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_stb_gen
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
